//--- game_top.f
design/game_pkg.sv
design/bus_pkg.sv
design/game_fsm.sv
design/player_mover.sv
design/enemy_mover.sv
design/frame_sequencer.sv
design/clear_engine.sv
design/sprite_painter.sv
design/pixel_arbiter.sv
design/game_top.sv
verif/game_asserts.sv
verif/game_tb.sv

//--- verif/game_tb.sv
//////////////////////////////////////////////////
// Testbench for game_top that drives the keys, acts
// as a frame buffer with random ready and checks each
// pixel write against a reference model
//////////////////////////////////////////////////
`timescale 1ns/1ps

module game_tb;

    localparam int CLEAR_WR = game_pkg::SCREEN_W * game_pkg::SCREEN_H;
    localparam int MAX_PLAY = 100;          // Frame cap while heading for a collision
    localparam int NE = game_pkg::NUM_ENEMIES;

    logic clk, resetn, go, left, right, fb_awvalid, fb_awready;
    bus_pkg::pixel_wr_t fb_aw, got_wr, exp_wr;
    bus_pkg::pixel_wr_t got_q[$];           // Accepted writes from the DUT
    bus_pkg::pixel_wr_t exp_q[$];           // Writes the reference model predicts
    int unsigned n_checked = 0;
    int px, frames;
    int ex [NE];
    int ey [NE];
    logic eleft [NE];
    logic eup [NE];
    logic hit;

    game_top dut (.clk(clk), .resetn(resetn), .go(go), .left(left), .right(right),
                  .fb_awvalid(fb_awvalid), .fb_awready(fb_awready), .fb_aw(fb_aw));

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic int paint_writes();
        int n;
        n = int'(game_pkg::PLAYER_W) * int'(game_pkg::PLAYER_W);
        for (int i = 0; i < NE; i++)
            n += int'(game_pkg::ENEMY_INIT[i].w) * int'(game_pkg::ENEMY_INIT[i].w);
        return n;
    endfunction

    function automatic void load_start_positions();
        px = game_pkg::PLAYER_START_X;
        for (int i = 0; i < NE; i++) begin
            ex[i] = game_pkg::ENEMY_INIT[i].x;
            ey[i] = game_pkg::ENEMY_INIT[i].y;
            eleft[i] = game_pkg::ENEMY_INIT[i].left;
            eup[i] = game_pkg::ENEMY_INIT[i].up;
        end
    endfunction

    // Direction after a step; flips where the next pixel would leave the screen
    function automatic logic turn(input int p, input int w, input logic back, input int limit);
        if (back)
            return p != 0;
        return p + w >= limit;
    endfunction

    function automatic void advance_world(input logic l, input logic r);
        int w;
        if (l && !r && px > 0)
            px = px - 1;
        else if (r && !l && px < game_pkg::SCREEN_W - game_pkg::PLAYER_W)
            px = px + 1;
        for (int i = 0; i < NE; i++) begin
            w = game_pkg::ENEMY_INIT[i].w;
            eleft[i] = turn(ex[i], w, eleft[i], game_pkg::SCREEN_W);
            eup[i] = turn(ey[i], w, eup[i], game_pkg::SCREEN_H);
            ex[i] = eleft[i] ? ex[i] - 1 : ex[i] + 1;
            ey[i] = eup[i] ? ey[i] - 1 : ey[i] + 1;
        end
    endfunction

    function automatic logic overlap_1d(input int a, input int aw, input int b, input int bw);
        return a < b + bw && b < a + aw;
    endfunction

    function automatic logic collision();
        logic any;
        int w;
        any = 1'b0;
        for (int i = 0; i < NE; i++) begin
            w = game_pkg::ENEMY_INIT[i].w;
            any |= overlap_1d(px, game_pkg::PLAYER_W, ex[i], w) &&
                   overlap_1d(game_pkg::PLAYER_START_Y, game_pkg::PLAYER_W, ey[i], w);
        end
        return any;
    endfunction

    function automatic void push_square(input int x, input int y, input int w,
                                        input game_pkg::colour_t c);
        for (int dy = 0; dy < w; dy++)
            for (int dx = 0; dx < w; dx++)
                exp_q.push_back('{addr: bus_pkg::fb_addr_t'((y + dy) * game_pkg::SCREEN_W
                                                            + x + dx), colour: c});
    endfunction

    // Expected writes of one frame as raster clear then player and enemies
    function automatic void push_frame(input logic with_paint);
        for (int a = 0; a < CLEAR_WR; a++)
            exp_q.push_back('{addr: bus_pkg::fb_addr_t'(a), colour: game_pkg::BG_COLOUR});
        if (with_paint) begin
            push_square(px, game_pkg::PLAYER_START_Y, game_pkg::PLAYER_W,
                        game_pkg::PLAYER_COLOUR);
            for (int i = 0; i < NE; i++)
                push_square(ex[i], ey[i], game_pkg::ENEMY_INIT[i].w,
                            game_pkg::ENEMY_INIT[i].colour);
        end
    endfunction

    task automatic abort_run();
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_pixel(input string name, input bus_pkg::pixel_wr_t got,
                               input bus_pkg::pixel_wr_t exp);
        if (got !== exp) begin
            $display("ERR %s write %0d: got %h (addr %h colour %h), %s",
                     name, n_checked, got, got.addr, got.colour,
                     $sformatf("expected %h (addr %h colour %h)",
                               exp, exp.addr, exp.colour));
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR %s: got %h, expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic press_go();
        @(posedge clk);
        go <= 1'b1;
        repeat (6) @(posedge clk);
        go <= 1'b0;
        repeat (6) @(posedge clk);
    endtask

    task automatic wait_drained();
        while (exp_q.size() != 0)
            @(negedge clk);
    endtask

    task automatic expect_silence(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            check_flag("fb_awvalid", fb_awvalid, 1'b0);
        end
        if (got_q.size() != 0) begin
            $display("The DUT made %0d pixel writes that no frame explains", got_q.size());
            abort_run();
        end
    endtask

    // Frame buffer with ready high three cycles in four
    initial begin
        fb_awready = 1'b0;
        void'($urandom(96));
        forever begin
            @(posedge clk);
            fb_awready <= ($urandom % 4) != 0;
        end
    end

    always @(posedge clk) begin
        if (resetn && fb_awvalid && fb_awready)
            got_q.push_back(fb_aw);
    end

    always @(negedge clk) begin
        while (got_q.size() > 0 && exp_q.size() > 0) begin
            got_wr = got_q.pop_front();
            exp_wr = exp_q.pop_front();
            check_pixel("fb_aw", got_wr, exp_wr);
            n_checked++;
        end
    end

    // Bound assertion failures end the run at once
    initial begin
        wait (dut.u_arb.u_asserts.fail_count != 0);
        $display("A bound assertion on the pixel channel failed");
        abort_run();
    end

    initial begin : watchdog
        int unsigned budget;
        budget = 4 * ((MAX_PLAY + 3) * CLEAR_WR + (MAX_PLAY + 2) * paint_writes()) + 2000;
        repeat (budget) @(posedge clk);
        $display("Timeout: the run did not end within %0d cycles", budget);
        abort_run();
    end

    initial begin
        resetn = 1'b0;
        go = 1'b0;
        left = 1'b0;
        right = 1'b0;
        repeat (10) @(posedge clk);
        resetn <= 1'b1;
        expect_silence(50);                 // Level select with go low

        press_go();                         // Level load frame
        load_start_positions();
        push_frame(1'b1);
        wait_drained();
        expect_silence(200);

        @(posedge clk);
        right <= 1'b1;
        press_go();                         // Pause into play
        frames = 0;
        hit = 1'b0;
        while (!hit && frames < MAX_PLAY) begin
            push_frame(1'b1);
            advance_world(1'b0, 1'b1);
            hit = collision();
            frames++;
            wait_drained();
        end
        if (!hit || frames < 40) begin
            $display("Play ran %0d frames, the collision must come after at least 40", frames);
            abort_run();
        end
        $display("Collision after %0d play frames", frames);
        push_frame(1'b0);                   // Game over blanks the screen
        wait_drained();
        expect_silence(300);

        @(posedge clk);
        right <= 1'b0;
        press_go();                         // Fresh level after game over
        load_start_positions();
        push_frame(1'b1);
        wait_drained();
        expect_silence(200);

        if (dut.u_arb.u_asserts.fail_count == 0) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            $display("%0d bound assertion failures", dut.u_arb.u_asserts.fail_count);
            $display("SOME TESTS FAILED");
            $fatal(1, "assertion failures");
        end
    end

endmodule

//--- verif/game_asserts.sv
//////////////////////////////////////////////////
// Checks on the shared pixel write channel and the
// grant, bound into every pixel_arbiter
//////////////////////////////////////////////////
`timescale 1ns/1ps

module game_asserts (
    input logic               clk,
    input logic               resetn,
    input logic               fb_awvalid,
    input logic               fb_awready,
    input bus_pkg::pixel_wr_t fb_aw,
    input logic               clear_req,
    input logic               paint_req,
    input logic               clear_gnt,
    input logic               paint_gnt
);

    int unsigned fail_count = 0;

    // A stalled write keeps valid and payload
    stall_holds: assert property (@(posedge clk) disable iff (!resetn)
        fb_awvalid && !fb_awready |=> fb_awvalid && $stable(fb_aw))
        else begin
            $error("write payload changed while stalled");
            fail_count++;
        end

    // The grant holder is the only engine asking for the channel
    one_owner: assert property (@(posedge clk) disable iff (!resetn)
        !(clear_gnt && paint_req) && !(paint_gnt && clear_req))
        else begin
            $error("an engine requests while the other holds the grant");
            fail_count++;
        end

    quiet_reset: assert property (@(posedge clk) !resetn |=> !fb_awvalid)
        else begin
            $error("fb_awvalid high after reset");
            fail_count++;
        end

endmodule

bind pixel_arbiter game_asserts u_asserts (
    .clk(clk), .resetn(resetn), .fb_awvalid(fb_awvalid), .fb_awready(fb_awready),
    .fb_aw(fb_aw), .clear_req(clear_req), .paint_req(paint_req),
    .clear_gnt(clear_gnt), .paint_gnt(paint_gnt)
);

//--- design/game_top.sv
//////////////////////////////////////////////////
// Game top level wiring the mode FSM, the movers, the
// frame sequencer and two write engines that share
// one pixel channel
//////////////////////////////////////////////////
`timescale 1ns/1ps

module game_top (
    input  logic               clk,
    input  logic               resetn,
    input  logic               go,
    input  logic               left,
    input  logic               right,
    output logic               fb_awvalid,
    input  logic               fb_awready,
    output bus_pkg::pixel_wr_t fb_aw
);

    game_pkg::game_mode_t mode;
    game_pkg::sprite_t player;
    game_pkg::sprite_t [game_pkg::NUM_ENEMIES-1:0] enemies;
    logic player_hit, step;
    logic clear_start, clear_done, paint_start, paint_done;
    logic clear_req, clear_valid, clear_ready;
    logic paint_req, paint_valid, paint_ready;
    bus_pkg::pixel_wr_t clear_wr, paint_wr;

    game_fsm u_fsm (
        .clk(clk), .resetn(resetn), .go(go), .player_hit(player_hit), .mode(mode)
    );

    player_mover u_player (
        .clk(clk), .resetn(resetn), .mode(mode), .step(step),
        .left(left), .right(right), .player(player)
    );

    enemy_mover u_enemies (
        .clk(clk), .resetn(resetn), .mode(mode), .step(step), .player(player),
        .enemies(enemies), .player_hit(player_hit)
    );

    frame_sequencer u_seq (
        .clk(clk), .resetn(resetn), .mode(mode),
        .clear_done(clear_done), .paint_done(paint_done),
        .clear_start(clear_start), .paint_start(paint_start), .step(step)
    );

    clear_engine u_clear (
        .clk(clk), .resetn(resetn), .start(clear_start),
        .req(clear_req), .valid(clear_valid), .wr(clear_wr),
        .ready(clear_ready), .done(clear_done)
    );

    sprite_painter u_paint (
        .clk(clk), .resetn(resetn), .start(paint_start),
        .player(player), .enemies(enemies),
        .req(paint_req), .valid(paint_valid), .wr(paint_wr),
        .ready(paint_ready), .done(paint_done)
    );

    pixel_arbiter u_arb (
        .clk(clk), .resetn(resetn),
        .clear_req(clear_req), .clear_valid(clear_valid),
        .clear_wr(clear_wr), .clear_ready(clear_ready),
        .paint_req(paint_req), .paint_valid(paint_valid),
        .paint_wr(paint_wr), .paint_ready(paint_ready),
        .fb_awvalid(fb_awvalid), .fb_awready(fb_awready), .fb_aw(fb_aw)
    );

endmodule

//--- design/pixel_arbiter.sv
//////////////////////////////////////////////////
// Grants the shared pixel write channel to one
// engine for a whole burst, clear engine first
//////////////////////////////////////////////////
`timescale 1ns/1ps

module pixel_arbiter (
    input  logic               clk,
    input  logic               resetn,
    input  logic               clear_req,
    input  logic               clear_valid,
    input  bus_pkg::pixel_wr_t clear_wr,
    output logic               clear_ready,
    input  logic               paint_req,
    input  logic               paint_valid,
    input  bus_pkg::pixel_wr_t paint_wr,
    output logic               paint_ready,
    output logic               fb_awvalid,
    input  logic               fb_awready,
    output bus_pkg::pixel_wr_t fb_aw
);

    typedef enum logic [1:0] {OWN_NONE, OWN_CLEAR, OWN_PAINT} owner_t;

    owner_t owner;
    logic clear_gnt, paint_gnt;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            owner <= OWN_NONE;
        end else begin
            case (owner)
                OWN_NONE: begin
                    if (clear_req)
                        owner <= OWN_CLEAR;
                    else if (paint_req)
                        owner <= OWN_PAINT;
                end
                OWN_CLEAR: if (!clear_req) owner <= OWN_NONE;
                OWN_PAINT: if (!paint_req) owner <= OWN_NONE;
                default:   owner <= OWN_NONE;
            endcase
        end
    end

    assign clear_gnt = owner == OWN_CLEAR;
    assign paint_gnt = owner == OWN_PAINT;

    assign fb_awvalid = (clear_gnt && clear_valid) || (paint_gnt && paint_valid);
    assign fb_aw = paint_gnt ? paint_wr : clear_wr;
    assign clear_ready = clear_gnt && fb_awready;   // Only the owner sees ready
    assign paint_ready = paint_gnt && fb_awready;

endmodule

//--- design/sprite_painter.sv
//////////////////////////////////////////////////
// Paints the player square and then each enemy
// square, row by row, as pixel writes
//////////////////////////////////////////////////
`timescale 1ns/1ps

module sprite_painter (
    input  logic                                          clk,
    input  logic                                          resetn,
    input  logic                                          start,
    input  game_pkg::sprite_t                             player,
    input  game_pkg::sprite_t [game_pkg::NUM_ENEMIES-1:0] enemies,
    output logic                                          req,
    output logic                                          valid,
    output bus_pkg::pixel_wr_t                            wr,
    input  logic                                          ready,
    output logic                                          done
);

    localparam int NSPR = game_pkg::NUM_ENEMIES + 1;

    game_pkg::sprite_t [NSPR-1:0] spr;     // Entry 0 is the player
    game_pkg::sprite_t cur;
    logic [$clog2(NSPR)-1:0] idx;
    game_pkg::size_t dx, dy;
    logic busy, row_end, sq_end;

    // Frame snapshot so the movers may step while we paint
    always_ff @(posedge clk) begin
        if (start)
            spr <= {enemies, player};
    end

    assign cur = spr[idx];
    assign row_end = dx == cur.w - 1'b1;
    assign sq_end = dy == cur.w - 1'b1;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            busy <= 1'b0;
            done <= 1'b0;
            idx <= '0;
            dx <= '0;
            dy <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                idx <= '0;
                dx <= '0;
                dy <= '0;
            end else if (valid && ready) begin
                dx <= row_end ? '0 : dx + 1'b1;
                if (row_end)
                    dy <= sq_end ? '0 : dy + 1'b1;
                if (row_end && sq_end && idx == NSPR - 1) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end else if (row_end && sq_end) begin
                    idx <= idx + 1'b1;     // Next sprite
                end
            end
        end
    end

    assign req = busy;
    assign valid = busy;
    assign wr = '{addr: bus_pkg::pix_addr(cur.x + game_pkg::coord_x_t'(dx),
                                          cur.y + game_pkg::coord_y_t'(dy)),
                  colour: cur.colour};

endmodule

//--- design/clear_engine.sv
//////////////////////////////////////////////////
// Raster scan writing the background colour to
// every screen pixel after a start pulse
//////////////////////////////////////////////////
`timescale 1ns/1ps

module clear_engine (
    input  logic               clk,
    input  logic               resetn,
    input  logic               start,
    output logic               req,
    output logic               valid,
    output bus_pkg::pixel_wr_t wr,
    input  logic               ready,
    output logic               done
);

    logic busy;
    logic row_end, last;
    game_pkg::coord_x_t x;
    game_pkg::coord_y_t y;

    assign row_end = x == game_pkg::coord_x_t'(game_pkg::SCREEN_W - 1);
    assign last = row_end && y == game_pkg::coord_y_t'(game_pkg::SCREEN_H - 1);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            busy <= 1'b0;
            done <= 1'b0;
            x <= '0;
            y <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                x <= '0;
                y <= '0;
            end else if (valid && ready) begin
                x <= row_end ? '0 : x + 1'b1;
                if (row_end)
                    y <= y + 1'b1;
                if (last) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    assign req = busy;      // Falls the cycle after the last transfer
    assign valid = busy;
    assign wr = '{addr: bus_pkg::pix_addr(x, y), colour: game_pkg::BG_COLOUR};

endmodule

//--- design/frame_sequencer.sv
//////////////////////////////////////////////////
// Orders each frame: clear, paint, then the mover
// step while playing
//////////////////////////////////////////////////
`timescale 1ns/1ps

module frame_sequencer (
    input  logic                 clk,
    input  logic                 resetn,
    input  game_pkg::game_mode_t mode,
    input  logic                 clear_done,
    input  logic                 paint_done,
    output logic                 clear_start,
    output logic                 paint_start,
    output logic                 step
);

    typedef enum logic [1:0] {IDLE, CLEARING, PAINTING, OVER} seq_state_t;

    seq_state_t state;
    game_pkg::game_mode_t frame_mode;   // Mode that launched the current frame
    logic [1:0] settle;                 // Lets player_hit reach the mode after a step

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= IDLE;
            frame_mode <= game_pkg::LEVEL_SELECT;
            settle <= '0;
            clear_start <= 1'b0;
            paint_start <= 1'b0;
            step <= 1'b0;
        end else begin
            clear_start <= 1'b0;
            paint_start <= 1'b0;
            step <= 1'b0;
            if (settle != '0)
                settle <= settle - 1'b1;
            case (state)
                IDLE: begin
                    if (settle == '0 && (mode == game_pkg::LOAD_LEVEL ||
                        mode == game_pkg::PLAY || mode == game_pkg::GAME_OVER)) begin
                        frame_mode <= mode;
                        clear_start <= 1'b1;
                        state <= CLEARING;
                    end
                end
                CLEARING: begin
                    if (clear_done && frame_mode == game_pkg::GAME_OVER) begin
                        state <= OVER;              // Game over shows a blank screen
                    end else if (clear_done) begin
                        paint_start <= 1'b1;
                        state <= PAINTING;
                    end
                end
                PAINTING: begin
                    if (paint_done && frame_mode == game_pkg::PLAY) begin
                        step <= 1'b1;
                        settle <= 2'd3;
                        state <= IDLE;
                    end else if (paint_done) begin
                        state <= OVER;
                    end
                end
                default: if (mode != frame_mode) state <= IDLE;   // One frame per entry
            endcase
        end
    end

endmodule

//--- design/enemy_mover.sv
//////////////////////////////////////////////////
// Bouncing enemy squares and the registered
// player overlap flag
//////////////////////////////////////////////////
`timescale 1ns/1ps

module enemy_mover (
    input  logic                                          clk,
    input  logic                                          resetn,
    input  game_pkg::game_mode_t                          mode,
    input  logic                                          step,
    input  game_pkg::sprite_t                             player,
    output game_pkg::sprite_t [game_pkg::NUM_ENEMIES-1:0] enemies,
    output logic                                          player_hit
);

    logic [game_pkg::NUM_ENEMIES-1:0] left, up;
    logic [game_pkg::NUM_ENEMIES-1:0] hit;
    logic [8:0] nx [game_pkg::NUM_ENEMIES];   // {new direction, new position}
    logic [8:0] ny [game_pkg::NUM_ENEMIES];

    // One pixel move on an axis; bounces in the same step at an edge
    function automatic logic [8:0] axis_step(input logic [7:0] p, input game_pkg::size_t w,
                                             input logic back, input int limit);
        logic back_next;
        back_next = back ? (p != 8'd0) : (int'(p) + int'(w) >= limit);
        return back_next ? {1'b1, p - 8'd1} : {1'b0, p + 8'd1};
    endfunction

    function automatic logic overlaps(input game_pkg::sprite_t a, input game_pkg::sprite_t b);
        return int'(a.x) < int'(b.x) + int'(b.w) && int'(b.x) < int'(a.x) + int'(a.w) &&
               int'(a.y) < int'(b.y) + int'(b.w) && int'(b.y) < int'(a.y) + int'(a.w);
    endfunction

    always_comb begin
        for (int i = 0; i < game_pkg::NUM_ENEMIES; i++) begin
            nx[i] = axis_step(enemies[i].x, enemies[i].w, left[i], game_pkg::SCREEN_W);
            ny[i] = axis_step({1'b0, enemies[i].y}, enemies[i].w, up[i], game_pkg::SCREEN_H);
            hit[i] = overlaps(player, enemies[i]);
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn || mode == game_pkg::LOAD_LEVEL) begin
            for (int i = 0; i < game_pkg::NUM_ENEMIES; i++) begin
                enemies[i] <= '{x: game_pkg::ENEMY_INIT[i].x, y: game_pkg::ENEMY_INIT[i].y,
                                w: game_pkg::ENEMY_INIT[i].w,
                                colour: game_pkg::ENEMY_INIT[i].colour};
                left[i] <= game_pkg::ENEMY_INIT[i].left;
                up[i] <= game_pkg::ENEMY_INIT[i].up;
            end
        end else if (step) begin
            for (int i = 0; i < game_pkg::NUM_ENEMIES; i++) begin
                enemies[i].x <= nx[i][7:0];
                enemies[i].y <= ny[i][6:0];
                left[i] <= nx[i][8];
                up[i] <= ny[i][8];
            end
        end
    end

    // Follows each position update by one cycle
    always_ff @(posedge clk) begin
        if (!resetn)
            player_hit <= 1'b0;
        else
            player_hit <= |hit;
    end

endmodule

//--- design/player_mover.sv
//////////////////////////////////////////////////
// Player square position, one pixel per frame step
// toward the held key, clamped to the screen
//////////////////////////////////////////////////
`timescale 1ns/1ps

module player_mover (
    input  logic                 clk,
    input  logic                 resetn,
    input  game_pkg::game_mode_t mode,
    input  logic                 step,
    input  logic                 left,
    input  logic                 right,
    output game_pkg::sprite_t    player
);

    localparam game_pkg::coord_x_t X_MAX =
        game_pkg::coord_x_t'(game_pkg::SCREEN_W - game_pkg::PLAYER_W);

    game_pkg::coord_x_t x;

    always_ff @(posedge clk) begin
        if (!resetn || mode == game_pkg::LOAD_LEVEL) begin
            x <= game_pkg::PLAYER_START_X;
        end else if (step) begin
            if (left && !right && x != '0)
                x <= x - 1'b1;
            else if (right && !left && x != X_MAX)
                x <= x + 1'b1;
        end
    end

    assign player = '{x: x, y: game_pkg::PLAYER_START_Y,
                      w: game_pkg::PLAYER_W, colour: game_pkg::PLAYER_COLOUR};

endmodule

//--- design/game_fsm.sv
//////////////////////////////////////////////////
// Game mode FSM stepped by the single go key
//////////////////////////////////////////////////
`timescale 1ns/1ps

module game_fsm (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 go,
    input  logic                 player_hit,
    output game_pkg::game_mode_t mode
);

    game_pkg::game_mode_t mode_next;

    // States alternate between waiting for press and for release,
    // so one held press moves a single state only
    always_comb begin
        mode_next = mode;
        case (mode)
            game_pkg::LEVEL_SELECT: if (go) mode_next = game_pkg::LOAD_LEVEL;
            game_pkg::LOAD_LEVEL:   if (!go) mode_next = game_pkg::LEVEL_PAUSE;
            game_pkg::LEVEL_PAUSE:  if (go) mode_next = game_pkg::PLAY_START;
            game_pkg::PLAY_START:   if (!go) mode_next = game_pkg::PLAY;
            game_pkg::PLAY: begin
                if (go)
                    mode_next = game_pkg::PAUSING;   // Pause wins over a hit
                else if (player_hit)
                    mode_next = game_pkg::GAME_OVER;
            end
            game_pkg::PAUSING:      if (!go) mode_next = game_pkg::LEVEL_PAUSE;
            game_pkg::GAME_OVER:    if (go) mode_next = game_pkg::LOAD_LEVEL;
            default:                mode_next = game_pkg::LEVEL_SELECT;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn)
            mode <= game_pkg::LEVEL_SELECT;
        else
            mode <= mode_next;
    end

endmodule

//--- design/bus_pkg.sv
//////////////////////////////////////////////////
// Frame-buffer address and the payload of the
// pixel write channel
//////////////////////////////////////////////////
package bus_pkg;

    typedef logic [14:0] fb_addr_t;

    typedef struct packed {
        fb_addr_t           addr;
        game_pkg::colour_t  colour;
    } pixel_wr_t;

    // Row-major pixel address
    function automatic fb_addr_t pix_addr(input game_pkg::coord_x_t x,
                                          input game_pkg::coord_y_t y);
        return fb_addr_t'(y) * fb_addr_t'(game_pkg::SCREEN_W) + fb_addr_t'(x);
    endfunction

endpackage

//--- design/game_pkg.sv
//////////////////////////////////////////////////
// Game-world types, screen size and the sprite table
// shared by the RTL and the testbench
//////////////////////////////////////////////////
package game_pkg;

    typedef logic [7:0] coord_x_t;
    typedef logic [6:0] coord_y_t;
    typedef logic [2:0] colour_t;   // One bit each of R, G, B
    typedef logic [2:0] size_t;

    localparam int SCREEN_W = 160;
    localparam int SCREEN_H = 120;
    localparam colour_t BG_COLOUR = 3'd0;

    localparam size_t PLAYER_W = 3'd3;
    localparam colour_t PLAYER_COLOUR = 3'd7;
    localparam coord_x_t PLAYER_START_X = 8'd78;
    localparam coord_y_t PLAYER_START_Y = 7'd116;

    // Square sprite handed from the movers to the painter
    typedef struct packed {
        coord_x_t x;
        coord_y_t y;
        size_t    w;
        colour_t  colour;
    } sprite_t;

    typedef struct packed {
        coord_x_t x;
        coord_y_t y;
        size_t    w;
        logic     left;     // Start direction on x
        logic     up;       // Start direction on y
        colour_t  colour;
    } enemy_init_t;

    localparam int NUM_ENEMIES = 3;
    localparam enemy_init_t ENEMY_INIT [NUM_ENEMIES] = '{
        '{x: 8'd80,  y: 7'd60,  w: 3'd3, left: 1'b0, up: 1'b0, colour: 3'd4},
        '{x: 8'd100, y: 7'd50,  w: 3'd5, left: 1'b1, up: 1'b0, colour: 3'd2},
        '{x: 8'd30,  y: 7'd100, w: 3'd7, left: 1'b0, up: 1'b1, colour: 3'd1}
    };

    typedef enum logic [2:0] {
        LEVEL_SELECT,
        LOAD_LEVEL,
        LEVEL_PAUSE,
        PLAY_START,
        PLAY,
        PAUSING,
        GAME_OVER
    } game_mode_t;

endpackage
